/* verilog/rv_exec_pkg.sv */
`default_nettype none

package rv_exec_pkg;

	// operand width of the integer datapath
	localparam int XLEN = 64;

	// 64-bit register value or result
	typedef logic [XLEN-1:0] word_t;

	// halfword aligned pc, bit 0 is always zero and not carried
	typedef logic [XLEN-1:1] pc_t;

	// major opcodes, instruction bits 6:2
	typedef enum logic [4:0] {
		OPC_LOAD     = 5'b00000,
		OPC_OP_IMM   = 5'b00100,
		OPC_AUIPC    = 5'b00101,
		OPC_OP_IMM32 = 5'b00110,
		OPC_STORE    = 5'b01000,
		OPC_OP       = 5'b01100,
		OPC_LUI      = 5'b01101,
		OPC_OP32     = 5'b01110,
		OPC_BRANCH   = 5'b11000,
		OPC_JALR     = 5'b11001,
		OPC_JAL      = 5'b11011
	} opcode_e;

	// result select for writeback
	typedef enum logic [3:0] {
		// adder results
		ALU_ADD     = 4'd0,
		ALU_ADDW    = 4'd1,
		// comparator, zero extended
		ALU_SLT     = 4'd2,
		// logic ops
		ALU_AND     = 4'd3,
		ALU_OR      = 4'd4,
		ALU_XOR     = 4'd5,
		// shifter, right shift covers srl and sra
		ALU_SLL     = 4'd6,
		ALU_SLLW    = 4'd7,
		ALU_SR      = 4'd8,
		ALU_SRW     = 4'd9,
		// immediate straight to rd
		ALU_LUI     = 4'd10,
		// memory address generation
		ALU_LOAD    = 4'd11,
		ALU_STORE   = 4'd12,
		// control flow
		ALU_BRANCH  = 4'd13,
		ALU_JUMP    = 4'd14,
		// anything not decoded
		ALU_ILLEGAL = 4'd15
	} alu_op_e;

endpackage

`default_nettype wire

/* verilog/rv_exec_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_exec_decode import rv_exec_pkg::*; (
	input  logic [4:0] opcode_i,
	input  logic [2:0] funct3_i,
	input  logic [6:0] funct7_i,
	input  word_t      rs1_i,
	input  word_t      rs2_i,
	input  logic [31:0] imm_i,
	input  pc_t        pc_i,
	input  pc_t        pcnext_i,

	output alu_op_e    alu_op_o,
	output word_t      add_a_o,
	output word_t      add_b_o,
	output logic       add_cin_o,
	output word_t      bit_a_o,
	output word_t      bit_b_o,
	output logic       cmp_signed_o,
	output logic       shift_arith_o,
	output logic       branch_on_eq_o,
	output logic       branch_invert_o,
	output logic [2:0] ram_funct3_o,
	output word_t      store_value_o,
	output word_t      lui_value_o,
	output word_t      link_value_o
);

	word_t imm_sext;
	word_t pc_word;

	// immediate sign extended to the full word
	assign imm_sext = {{32{imm_i[31]}}, imm_i};
	assign pc_word = {pc_i, 1'b0};

	// side values straight to writeback
	assign ram_funct3_o = funct3_i;
	assign store_value_o = rs2_i;
	assign lui_value_o = imm_sext;
	// return address for jal and jalr
	assign link_value_o = {pcnext_i, 1'b0};

	always_comb begin
		// undecoded falls through as illegal
		alu_op_o = ALU_ILLEGAL;
		// adder defaults to rs1 + imm, the address form
		add_a_o = rs1_i;
		add_b_o = imm_sext;
		add_cin_o = 1'b0;
		// bit unit defaults to rs1 against rs2
		bit_a_o = rs1_i;
		bit_b_o = rs2_i;
		// slt/sltu pick signedness from funct3 bit 0
		cmp_signed_o = ~funct3_i[0];
		shift_arith_o = 1'b0;
		branch_on_eq_o = 1'b0;
		branch_invert_o = 1'b0;

		case (opcode_e'(opcode_i))
			// lb .. lwu, funct3 7 unused
			OPC_LOAD: begin
				if (funct3_i != 3'b111)
					alu_op_o = ALU_LOAD;
			end

			// sb .. sd only
			OPC_STORE: begin
				if (!funct3_i[2])
					alu_op_o = ALU_STORE;
			end

			OPC_OP_IMM: begin
				bit_b_o = imm_sext;
				// imm bit 10 is funct7 bit 5 for srai
				shift_arith_o = imm_i[10];
				case (funct3_i)
					3'b000: alu_op_o = ALU_ADD;
					// slli, 6-bit shamt, rest of the field must be zero
					3'b001: if (imm_i[11:6] == 6'b0) alu_op_o = ALU_SLL;
					3'b010, 3'b011: alu_op_o = ALU_SLT;
					3'b100: alu_op_o = ALU_XOR;
					// srli / srai
					3'b101: if ({imm_i[11], imm_i[9:6]} == 5'b0) alu_op_o = ALU_SR;
					3'b110: alu_op_o = ALU_OR;
					default: alu_op_o = ALU_AND;
				endcase
			end

			OPC_OP_IMM32: begin
				bit_b_o = imm_sext;
				shift_arith_o = imm_i[10];
				case (funct3_i)
					3'b000: alu_op_o = ALU_ADDW;
					// word shifts take a 5-bit shamt
					3'b001: if (imm_i[11:5] == 7'b0) alu_op_o = ALU_SLLW;
					3'b101: if ({imm_i[11], imm_i[9:5]} == 6'b0) alu_op_o = ALU_SRW;
					default: alu_op_o = ALU_ILLEGAL;
				endcase
			end

			OPC_OP: begin
				// sub as rs1 + ~rs2 + 1
				add_b_o = funct7_i[5] ? ~rs2_i : rs2_i;
				add_cin_o = funct7_i[5];
				shift_arith_o = funct7_i[5];
				case ({funct3_i, funct7_i}) inside
					10'b000_0?00000: alu_op_o = ALU_ADD;
					10'b001_0000000: alu_op_o = ALU_SLL;
					10'b01?_0000000: alu_op_o = ALU_SLT;
					10'b100_0000000: alu_op_o = ALU_XOR;
					10'b101_0?00000: alu_op_o = ALU_SR;
					10'b110_0000000: alu_op_o = ALU_OR;
					10'b111_0000000: alu_op_o = ALU_AND;
					default: alu_op_o = ALU_ILLEGAL;
				endcase
			end

			OPC_OP32: begin
				add_b_o = funct7_i[5] ? ~rs2_i : rs2_i;
				add_cin_o = funct7_i[5];
				shift_arith_o = funct7_i[5];
				case ({funct3_i, funct7_i}) inside
					10'b000_0?00000: alu_op_o = ALU_ADDW;
					10'b001_0000000: alu_op_o = ALU_SLLW;
					10'b101_0?00000: alu_op_o = ALU_SRW;
					default: alu_op_o = ALU_ILLEGAL;
				endcase
			end

			OPC_LUI: alu_op_o = ALU_LUI;

			// pc + imm through the adder
			OPC_AUIPC: begin
				add_a_o = pc_word;
				alu_op_o = ALU_ADD;
			end

			OPC_BRANCH: begin
				// target is pc + imm, condition from rs1 vs rs2
				add_a_o = pc_word;
				cmp_signed_o = ~funct3_i[1];
				// beq/bne use eq, the rest use lt
				branch_on_eq_o = ~funct3_i[2];
				// odd funct3 inverts: bne, bge, bgeu
				branch_invert_o = funct3_i[0];
				if (funct3_i[2:1] != 2'b01)
					alu_op_o = ALU_BRANCH;
			end

			// target rs1 + imm
			OPC_JALR: alu_op_o = ALU_JUMP;

			OPC_JAL: begin
				add_a_o = pc_word;
				alu_op_o = ALU_JUMP;
			end

			default: alu_op_o = ALU_ILLEGAL;
		endcase
	end

	// even x inputs must land on a defined op, so sigill stays clean
	assert final (!$isunknown(alu_op_o))
		else $error("decode produced unknown alu_op");

endmodule

`default_nettype wire

/* verilog/rv_add_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_add_unit #(
	parameter int width = 64
) (
	input  logic [width-1:0] add_a_i,
	input  logic [width-1:0] add_b_i,
	input  logic             add_cin_i,

	output logic [width-1:0] sum_o,
	output logic [width-1:0] sum_w_o
);

	localparam int half = width / 2;

	// one adder for add, sub, addresses and targets
	// cin is set for sub, where b is already inverted
	assign sum_o = add_a_i + add_b_i + width'(add_cin_i);

	// word form: low half of the same sum,
	// sign bit of the low half copied up
	assign sum_w_o = {{half{sum_o[half-1]}}, sum_o[half-1:0]};

endmodule

`default_nettype wire

/* verilog/rv_bit_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_bit_unit #(
	parameter int width = 64
) (
	input  logic [width-1:0] bit_a_i,
	input  logic [width-1:0] bit_b_i,
	input  logic             cmp_signed_i,
	input  logic             shift_arith_i,

	output logic             lt_o,
	output logic             eq_o,
	output logic [width-1:0] and_out_o,
	output logic [width-1:0] or_out_o,
	output logic [width-1:0] xor_out_o,
	output logic [width-1:0] sll_out_o,
	output logic [width-1:0] sllw_out_o,
	output logic [width-1:0] sr_out_o,
	output logic [width-1:0] srw_out_o
);

	localparam int half = width / 2;
	localparam int stages = $clog2(width);

	logic [stages-1:0] shamt;
	logic [width-1:0] sll_v;
	logic [width-1:0] sr_v;
	logic [half-1:0] sllw_v;
	logic [half-1:0] srw_v;
	logic fill;
	logic fill_w;

	// compare bits lo..hi, returns {lt, eq}
	// split in halves, upper half decides unless equal
	function automatic logic [1:0] cmp_range(
		input logic [width-1:0] a,
		input logic [width-1:0] b,
		input int lo,
		input int hi,
		input logic sgn
	);
		int mid;
		logic [1:0] lo_r;
		logic [1:0] hi_r;
		if (lo == hi) begin
			// single bit, signed only ever reaches the msb
			if (sgn)
				return {a[lo] & ~b[lo], ~(a[lo] ^ b[lo])};
			return {~a[lo] & b[lo], ~(a[lo] ^ b[lo])};
		end
		mid = (lo + hi) / 2;
		// lower half is always unsigned
		lo_r = cmp_range(a, b, lo, mid, 1'b0);
		hi_r = cmp_range(a, b, mid + 1, hi, sgn);
		return {hi_r[1] | (hi_r[0] & lo_r[1]), hi_r[0] & lo_r[0]};
	endfunction

	always_comb begin
		{lt_o, eq_o} = cmp_range(bit_a_i, bit_b_i, 0, width - 1, cmp_signed_i);
	end

	// logic ops, xor built from and/or
	assign and_out_o = bit_a_i & bit_b_i;
	assign or_out_o = bit_a_i | bit_b_i;
	assign xor_out_o = or_out_o & ~and_out_o;

	// shift amount in the low bits of b
	assign shamt = bit_b_i[stages-1:0];
	// fill bits for arithmetic right shift
	assign fill = bit_a_i[width-1] & shift_arith_i;
	assign fill_w = bit_a_i[half-1] & shift_arith_i;

	always_comb begin
		sll_v = bit_a_i;
		sr_v = bit_a_i;
		sllw_v = bit_a_i[half-1:0];
		srw_v = bit_a_i[half-1:0];
		// one stage per shamt bit, 1, 2, 4 ..
		for (int s = 0; s < stages; s++) begin
			if (shamt[s]) begin
				sll_v = sll_v << (1 << s);
				sr_v = (sr_v >> (1 << s)) | ({width{fill}} & ~({width{1'b1}} >> (1 << s)));
				// word variants skip the top stage
				if (s < stages - 1) begin
					sllw_v = sllw_v << (1 << s);
					srw_v = (srw_v >> (1 << s)) | ({half{fill_w}} & ~({half{1'b1}} >> (1 << s)));
				end
			end
		end
	end

	assign sll_out_o = sll_v;
	assign sr_out_o = sr_v;
	// word results sign extended from bit half-1
	assign sllw_out_o = {{half{sllw_v[half-1]}}, sllw_v};
	assign srw_out_o = {{half{srw_v[half-1]}}, srw_v};

endmodule

`default_nettype wire

/* verilog/rv_exec_writeback.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_exec_writeback import rv_exec_pkg::*; (
	input  logic       clk,
	input  logic       reset_i,
	input  logic       valid_i,
	input  alu_op_e    alu_op_i,
	input  word_t      sum_i,
	input  word_t      sum_w_i,
	input  logic       lt_i,
	input  logic       eq_i,
	input  word_t      and_out_i,
	input  word_t      or_out_i,
	input  word_t      xor_out_i,
	input  word_t      sll_out_i,
	input  word_t      sllw_out_i,
	input  word_t      sr_out_i,
	input  word_t      srw_out_i,
	input  logic       branch_on_eq_i,
	input  logic       branch_invert_i,
	input  logic [2:0] ram_funct3_i,
	input  word_t      store_value_i,
	input  word_t      lui_value_i,
	input  word_t      link_value_i,
	input  pc_t        pcnext_i,

	output logic       valid_o,
	output logic       sigill_o,
	output word_t      rd_o,
	output pc_t        pcnext_o,
	output logic       ram_load_o,
	output logic       ram_store_o,
	output logic [2:0] ram_funct3_o,
	output word_t      ram_address_o,
	output word_t      ram_store_value_o
);

	word_t rd_d;
	logic taken;
	logic jump;

	// rd mux
	always_comb begin
		case (alu_op_i)
			ALU_ADD:  rd_d = sum_i;
			ALU_ADDW: rd_d = sum_w_i;
			ALU_SLT:  rd_d = {{($bits(word_t) - 1){1'b0}}, lt_i};
			ALU_AND:  rd_d = and_out_i;
			ALU_OR:   rd_d = or_out_i;
			ALU_XOR:  rd_d = xor_out_i;
			ALU_SLL:  rd_d = sll_out_i;
			ALU_SLLW: rd_d = sllw_out_i;
			ALU_SR:   rd_d = sr_out_i;
			ALU_SRW:  rd_d = srw_out_i;
			ALU_LUI:  rd_d = lui_value_i;
			ALU_JUMP: rd_d = link_value_i;
			// loads, stores, branches write no rd here
			default:  rd_d = '0;
		endcase
	end

	// branch condition, inverted for bne/bge/bgeu
	assign taken = (branch_on_eq_i ? eq_i : lt_i) ^ branch_invert_i;
	// idle cycles never redirect
	assign jump = valid_i & ((alu_op_i == ALU_JUMP) | ((alu_op_i == ALU_BRANCH) & taken));

	always_ff @(posedge clk) begin
		if (reset_i) begin
			valid_o <= 1'b0;
			sigill_o <= 1'b0;
			ram_load_o <= 1'b0;
			ram_store_o <= 1'b0;
			rd_o <= '0;
			pcnext_o <= '0;
			ram_funct3_o <= '0;
			ram_address_o <= '0;
			ram_store_value_o <= '0;
		end else begin
			// strobes only for a valid instruction
			valid_o <= valid_i;
			sigill_o <= valid_i & (alu_op_i == ALU_ILLEGAL);
			ram_load_o <= valid_i & (alu_op_i == ALU_LOAD);
			ram_store_o <= valid_i & (alu_op_i == ALU_STORE);
			rd_o <= rd_d;
			// target drops bit 0, jalr needs that
			pcnext_o <= jump ? sum_i[$bits(word_t)-1:1] : pcnext_i;
			ram_funct3_o <= ram_funct3_i;
			ram_address_o <= sum_i;
			ram_store_value_o <= store_value_i;
		end
	end

	// memory side sees at most one request per cycle
	assert property (@(posedge clk) disable iff (reset_i) !(ram_load_o && ram_store_o))
		else $error("load and store strobes both high");

	// a trapped instruction must not touch memory
	assert property (@(posedge clk) disable iff (reset_i) sigill_o |-> !(ram_load_o || ram_store_o))
		else $error("memory strobe with sigill");

endmodule

`default_nettype wire

/* verilog/rv_exec_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_exec_top import rv_exec_pkg::*; (
	input  logic        clk,
	input  logic        reset_i,
	input  logic        valid_i,
	input  logic [4:0]  opcode_i,
	input  logic [2:0]  funct3_i,
	input  logic [6:0]  funct7_i,
	input  word_t       rs1_i,
	input  word_t       rs2_i,
	input  logic [31:0] imm_i,
	input  pc_t         pc_i,
	input  pc_t         pcnext_i,

	output logic        valid_o,
	output logic        sigill_o,
	output word_t       rd_o,
	output pc_t         pcnext_o,
	output logic        ram_load_o,
	output logic        ram_store_o,
	output logic [2:0]  ram_funct3_o,
	output word_t       ram_address_o,
	output word_t       ram_store_value_o
);

	// decode to units
	alu_op_e alu_op;
	word_t add_a;
	word_t add_b;
	logic add_cin;
	word_t bit_a;
	word_t bit_b;
	logic cmp_signed;
	logic shift_arith;
	// decode to writeback
	logic branch_on_eq;
	logic branch_invert;
	logic [2:0] ram_funct3;
	word_t store_value;
	word_t lui_value;
	word_t link_value;
	// unit results
	word_t sum;
	word_t sum_w;
	logic lt;
	logic eq;
	word_t and_out;
	word_t or_out;
	word_t xor_out;
	word_t sll_out;
	word_t sllw_out;
	word_t sr_out;
	word_t srw_out;

	rv_exec_decode u_decode (
		.opcode_i(opcode_i), .funct3_i(funct3_i), .funct7_i(funct7_i),
		.rs1_i(rs1_i), .rs2_i(rs2_i), .imm_i(imm_i),
		.pc_i(pc_i), .pcnext_i(pcnext_i),
		.alu_op_o(alu_op),
		.add_a_o(add_a), .add_b_o(add_b), .add_cin_o(add_cin),
		.bit_a_o(bit_a), .bit_b_o(bit_b),
		.cmp_signed_o(cmp_signed), .shift_arith_o(shift_arith),
		.branch_on_eq_o(branch_on_eq), .branch_invert_o(branch_invert),
		.ram_funct3_o(ram_funct3), .store_value_o(store_value),
		.lui_value_o(lui_value), .link_value_o(link_value)
	);

	// adder and bit unit run side by side
	rv_add_unit #(.width(XLEN)) u_add (
		.add_a_i(add_a), .add_b_i(add_b), .add_cin_i(add_cin),
		.sum_o(sum), .sum_w_o(sum_w)
	);

	rv_bit_unit #(.width(XLEN)) u_bit (
		.bit_a_i(bit_a), .bit_b_i(bit_b),
		.cmp_signed_i(cmp_signed), .shift_arith_i(shift_arith),
		.lt_o(lt), .eq_o(eq),
		.and_out_o(and_out), .or_out_o(or_out), .xor_out_o(xor_out),
		.sll_out_o(sll_out), .sllw_out_o(sllw_out),
		.sr_out_o(sr_out), .srw_out_o(srw_out)
	);

	// single register stage, one cycle latency
	rv_exec_writeback u_wb (
		.clk(clk), .reset_i(reset_i), .valid_i(valid_i), .alu_op_i(alu_op),
		.sum_i(sum), .sum_w_i(sum_w), .lt_i(lt), .eq_i(eq),
		.and_out_i(and_out), .or_out_i(or_out), .xor_out_i(xor_out),
		.sll_out_i(sll_out), .sllw_out_i(sllw_out),
		.sr_out_i(sr_out), .srw_out_i(srw_out),
		.branch_on_eq_i(branch_on_eq), .branch_invert_i(branch_invert),
		.ram_funct3_i(ram_funct3), .store_value_i(store_value),
		.lui_value_i(lui_value), .link_value_i(link_value), .pcnext_i(pcnext_i),
		.valid_o(valid_o), .sigill_o(sigill_o), .rd_o(rd_o), .pcnext_o(pcnext_o),
		.ram_load_o(ram_load_o), .ram_store_o(ram_store_o),
		.ram_funct3_o(ram_funct3_o), .ram_address_o(ram_address_o),
		.ram_store_value_o(ram_store_value_o)
	);

endmodule

`default_nettype wire

/* verif/rv_exec_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_exec_tb import rv_exec_pkg::*; ();

	// one vector as read from the data file
	typedef struct packed {
		logic [4:0] opcode;
		logic [2:0] funct3;
		logic [6:0] funct7;
		word_t rs1;
		word_t rs2;
		logic [31:0] imm;
		word_t pc;
		word_t pcnext;
	} vec_in_t;

	// expected results, mask bit 0 is rd, bit 1 the memory side
	typedef struct packed {
		logic sigill;
		word_t rd;
		word_t pcnext;
		logic load;
		logic store;
		word_t addr;
		word_t store_value;
		logic [2:0] funct3;
		logic [1:0] mask;
	} vec_exp_t;

	logic clk;
	logic reset_i;
	logic valid_i;
	logic [4:0] opcode_i;
	logic [2:0] funct3_i;
	logic [6:0] funct7_i;
	word_t rs1_i;
	word_t rs2_i;
	logic [31:0] imm_i;
	pc_t pc_i;
	pc_t pcnext_i;
	logic valid_o;
	logic sigill_o;
	word_t rd_o;
	pc_t pcnext_o;
	logic ram_load_o;
	logic ram_store_o;
	logic [2:0] ram_funct3_o;
	word_t ram_address_o;
	word_t ram_store_value_o;

	vec_in_t vecs[$];
	vec_exp_t exps[$];
	string names[$];
	// in flight, one entry per driven instruction
	vec_exp_t expect_q[$];
	string name_q[$];
	// cycle in which each result is due
	int due_q[$];
	int errors;
	int checked;
	int cycles;
	int cycle_limit;

	rv_exec_top rv_exec_top_inst (
		.clk(clk), .reset_i(reset_i), .valid_i(valid_i),
		.opcode_i(opcode_i), .funct3_i(funct3_i), .funct7_i(funct7_i),
		.rs1_i(rs1_i), .rs2_i(rs2_i), .imm_i(imm_i),
		.pc_i(pc_i), .pcnext_i(pcnext_i),
		.valid_o(valid_o), .sigill_o(sigill_o), .rd_o(rd_o), .pcnext_o(pcnext_o),
		.ram_load_o(ram_load_o), .ram_store_o(ram_store_o),
		.ram_funct3_o(ram_funct3_o), .ram_address_o(ram_address_o),
		.ram_store_value_o(ram_store_value_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic read_vectors();
		int fd;
		int n;
		string line;
		logic [95:0] name_raw;
		logic [63:0] col[15];
		vec_in_t vi;
		vec_exp_t ve;
		fd = $fopen("verif/rv_exec_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open the test data file");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// blank lines and column notes
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name_raw,
				col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
				col[8], col[9], col[10], col[11], col[12], col[13], col[14]);
			if (n != 16) begin
				$display("malformed line in the test data file: %s", line);
				errors++;
				continue;
			end
			vi = {col[0][4:0], col[1][2:0], col[2][6:0], col[3], col[4], col[5][31:0],
				col[6], col[7]};
			// stores echo rs2 and funct3 on the memory side
			ve = {col[8][0], col[9], col[10], col[11][0], col[12][0], col[13],
				col[4], col[1][2:0], col[14][1:0]};
			vecs.push_back(vi);
			exps.push_back(ve);
			names.push_back(string'(name_raw));
		end
		$fclose(fd);
	endtask

	// drive one vector, queue what it should produce
	task automatic apply_vector(input int idx);
		valid_i = 1'b1;
		opcode_i = vecs[idx].opcode;
		funct3_i = vecs[idx].funct3;
		funct7_i = vecs[idx].funct7;
		rs1_i = vecs[idx].rs1;
		rs2_i = vecs[idx].rs2;
		imm_i = vecs[idx].imm;
		pc_i = vecs[idx].pc[63:1];
		pcnext_i = vecs[idx].pcnext[63:1];
		expect_q.push_back(exps[idx]);
		name_q.push_back(names[idx]);
		// registered on the next edge, one cycle latency
		due_q.push_back(cycles + 1);
	endtask

	task automatic compare_outputs(input vec_exp_t e, input string name);
		checked++;
		check_value({name, " sigill"}, e.sigill, sigill_o);
		check_value({name, " load"}, e.load, ram_load_o);
		check_value({name, " store"}, e.store, ram_store_o);
		check_value({name, " pcnext"}, e.pcnext, {pcnext_o, 1'b0});
		if (e.mask[0])
			check_value({name, " rd"}, e.rd, rd_o);
		if (e.mask[1]) begin
			check_value({name, " address"}, e.addr, ram_address_o);
			check_value({name, " funct3"}, e.funct3, ram_funct3_o);
		end
		if (e.store)
			check_value({name, " store value"}, e.store_value, ram_store_value_o);
	endtask

	// outputs are stable mid cycle
	always @(negedge clk) begin
		if (reset_i === 1'b0) begin
			if (valid_o === 1'b1) begin
				if (expect_q.size() == 0) begin
					$display("valid_o went high with no instruction outstanding");
					errors++;
				end else begin
					check_value({name_q[0], " cycle"}, due_q.pop_front(), cycles);
					compare_outputs(expect_q.pop_front(), name_q.pop_front());
				end
			end else begin
				// idle or reset, no strobe may leak through
				check_value("idle valid", 0, valid_o);
				check_value("idle sigill", 0, sigill_o);
				check_value("idle load", 0, ram_load_o);
				check_value("idle store", 0, ram_store_o);
			end
		end
	end

	// watchdog
	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("run did not finish within %0d cycles", cycle_limit);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		int gap;
		void'($urandom(32'hf1c2));
		errors = 0;
		checked = 0;
		cycles = 0;
		cycle_limit = 0;
		reset_i = 1'b1;
		valid_i = 1'b0;
		opcode_i = '0;
		funct3_i = '0;
		funct7_i = '0;
		rs1_i = '0;
		rs2_i = '0;
		imm_i = '0;
		pc_i = '0;
		pcnext_i = '0;
		read_vectors();
		// reset, up to three cycles per vector, slack for drain
		cycle_limit = 4 + 3 * vecs.size() + 20;
		repeat (4) @(posedge clk);
		#1;
		reset_i = 1'b0;
		// a few idle cycles before the first instruction
		repeat (2) @(posedge clk);
		foreach (vecs[i]) begin
			@(posedge clk);
			#1;
			apply_vector(i);
			// mostly back to back, now and then a short gap
			gap = ($urandom_range(3, 0) == 0) ? $urandom_range(2, 1) : 0;
			repeat (gap) begin
				@(posedge clk);
				#1;
				valid_i = 1'b0;
			end
		end
		@(posedge clk);
		#1;
		valid_i = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		if (expect_q.size() != 0) begin
			$display("%0d instructions never came out of the DUT", expect_q.size());
			errors++;
		end
		$display("%0d errors in %0d checked instructions", errors, checked);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/rv_exec_testdata.txt */
# name opcode funct3 funct7 rs1 rs2 imm pc pcnext | sigill rd pcnext load store address mask
# all hex, pc and pcnext as byte addresses, mask bit 0 checks rd, bit 1 address and funct3
add      0c 0 00 5 3 0 1000 1004 0 8 1004 0 0 0 1
sub      0c 0 20 3 5 0 1000 1004 0 fffffffffffffffe 1004 0 0 0 1
addi     04 0 00 10 0 ffffffff 1000 1004 0 f 1004 0 0 0 1
addw     0e 0 00 7fffffff 1 0 1000 1004 0 ffffffff80000000 1004 0 0 0 1
subw     0e 0 20 0 1 0 1000 1004 0 ffffffffffffffff 1004 0 0 0 1
addiw    06 0 00 ffffffff 0 1 1000 1004 0 0 1004 0 0 0 1
slt      0c 2 00 ffffffffffffffff 1 0 1000 1004 0 1 1004 0 0 0 1
sltu     0c 3 00 ffffffffffffffff 1 0 1000 1004 0 0 1004 0 0 0 1
slti     04 2 00 ffffffffffffffff 0 0 1000 1004 0 1 1004 0 0 0 1
sltiu    04 3 00 5 0 ffffffff 1000 1004 0 1 1004 0 0 0 1
and      0c 7 00 ff00ff00ff00ff00 0ff00ff00ff00ff0 0 1000 1004 0 0f000f000f000f00 1004 0 0 0 1
or       0c 6 00 ff00ff00ff00ff00 0ff00ff00ff00ff0 0 1000 1004 0 fff0fff0fff0fff0 1004 0 0 0 1
xor      0c 4 00 ff00ff00ff00ff00 0ff00ff00ff00ff0 0 1000 1004 0 f0f0f0f0f0f0f0f0 1004 0 0 0 1
xori     04 4 00 ff 0 ffffffff 1000 1004 0 ffffffffffffff00 1004 0 0 0 1
lui      0d 0 00 0 0 80000000 1000 1004 0 ffffffff80000000 1004 0 0 0 1
auipc    05 0 00 0 0 2000 1000 1004 0 3000 1004 0 0 0 1
sll0     0c 1 00 8000000000000001 0 0 1000 1004 0 8000000000000001 1004 0 0 0 1
slli1    04 1 00 8000000000000001 0 1 1000 1004 0 2 1004 0 0 0 1
slli63   04 1 00 1 0 3f 1000 1004 0 8000000000000000 1004 0 0 0 1
srli63   04 5 00 8000000000000000 0 3f 1000 1004 0 1 1004 0 0 0 1
srai63   04 5 00 8000000000000000 0 43f 1000 1004 0 ffffffffffffffff 1004 0 0 0 1
sra4     0c 5 20 f000000000000000 4 0 1000 1004 0 ff00000000000000 1004 0 0 0 1
slliw31  06 1 00 1 0 1f 1000 1004 0 ffffffff80000000 1004 0 0 0 1
sraiw31  06 5 00 80000000 0 41f 1000 1004 0 ffffffffffffffff 1004 0 0 0 1
srliw31  06 5 00 80000000 0 1f 1000 1004 0 1 1004 0 0 0 1
sllw     0e 1 00 1 21 0 1000 1004 0 2 1004 0 0 0 1
beq      18 0 00 5 5 10 1000 1004 0 0 1010 0 0 0 0
bne      18 1 00 5 5 10 1000 1004 0 0 1004 0 0 0 0
blt      18 4 00 ffffffffffffffff 1 10 1000 1004 0 0 1010 0 0 0 0
bge      18 5 00 5 5 10 1000 1004 0 0 1010 0 0 0 0
bltu     18 6 00 ffffffffffffffff 1 10 1000 1004 0 0 1004 0 0 0 0
bgeu     18 7 00 ffffffffffffffff 1 10 1000 1004 0 0 1010 0 0 0 0
bltu_t   18 6 00 1 ffffffffffffffff 10 1000 1004 0 0 1010 0 0 0 0
bne_back 18 1 00 1 2 fffffff0 1000 1004 0 0 0ff0 0 0 0 0
jal      1b 0 00 0 0 100 1000 1004 0 1004 1100 0 0 0 1
jalr     19 0 00 2001 0 4 1000 1004 0 1004 2004 0 0 0 1
ld       00 3 00 8000 0 fffffff8 1000 1004 0 0 1004 1 0 7ff8 2
lwu      00 6 00 100 0 4 1000 1004 0 0 1004 1 0 104 2
sd       08 3 00 8000 deadbeefcafef00d 10 1000 1004 0 0 1004 0 1 8010 2
sb       08 0 00 100 ff 0 1000 1004 0 0 1004 0 1 100 2
ill_ld   00 7 00 0 0 0 1000 1004 1 0 1004 0 0 0 0
ill_st   08 4 00 0 0 0 1000 1004 1 0 1004 0 0 0 0
ill_br   18 2 00 5 5 10 1000 1004 1 0 1004 0 0 0 0
ill_opc  1c 0 00 0 0 0 1000 1004 1 0 1004 0 0 0 0
ill_slli 04 1 00 1 0 801 1000 1004 1 0 1004 0 0 0 0
ill_mul  0c 0 01 5 3 0 1000 1004 1 0 1004 0 0 0 0

/* flist.f */
verilog/rv_exec_pkg.sv
verilog/rv_exec_decode.sv
verilog/rv_add_unit.sv
verilog/rv_bit_unit.sv
verilog/rv_exec_writeback.sv
verilog/rv_exec_top.sv
verif/rv_exec_tb.sv

/* Bender.yml */
package:
  name: rv_exec

sources:
  - verilog/rv_exec_pkg.sv
  - verilog/rv_exec_decode.sv
  - verilog/rv_add_unit.sv
  - verilog/rv_bit_unit.sv
  - verilog/rv_exec_writeback.sv
  - verilog/rv_exec_top.sv
  - target: test
    files:
      - verif/rv_exec_tb.sv
